/* design/x_core_pkg.sv */
package x_core_pkg;

  ////////////////////////////////////////////////////////////
  // register file
  ////////////////////////////////////////////////////////////

  // integer registers of the core
  localparam int unsigned NR_REGS    = 32;
  localparam int unsigned REG_ADDR_W = 5;

  ////////////////////////////////////////////////////////////
  // privilege
  ////////////////////////////////////////////////////////////

  // encoding follows the mstatus.mpp field
  typedef enum logic [1:0] {
    PRIV_LVL_M = 2'b11,
    PRIV_LVL_H = 2'b10,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_U = 2'b00
  } priv_lvl_e;

  ////////////////////////////////////////////////////////////
  // pipeline write ports
  ////////////////////////////////////////////////////////////

  // destination of one pipeline stage
  typedef struct packed {
    logic [REG_ADDR_W-1:0] addr;
    logic                  we;
  } pipe_wport_t;

endpackage

/* design/x_if_pkg.sv */
package x_if_pkg;

  // result rd is a core register address
  import x_core_pkg::*;

  ////////////////////////////////////////////////////////////
  // interface dimensions
  ////////////////////////////////////////////////////////////

  // source operands per instruction
  localparam int unsigned RF_READ_PORTS = 3;
  // rolling offload id
  localparam int unsigned X_ID_W        = 4;
  localparam int unsigned X_MODE_W      = 2;

  ////////////////////////////////////////////////////////////
  // issue channel
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [RF_READ_PORTS-1:0] rs_valid;
    logic [X_ID_W-1:0]        id;
    logic [X_MODE_W-1:0]      mode;
  } x_issue_req_t;

  // coprocessor answer to an offer
  typedef struct packed {
    logic accept;
    logic writeback;
    logic loadstore;
  } x_issue_resp_t;

  ////////////////////////////////////////////////////////////
  // commit and result channels
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [X_ID_W-1:0] id;
    logic              kill;
  } x_commit_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic                  we;
  } x_result_t;

  // per operand view handed from the checkers to the dispatcher
  typedef struct packed {
    logic ready;
    logic ex_fwd;
    logic wb_fwd;
    logic dep;
  } operand_status_t;

endpackage

/* design/x_scoreboard.sv */
`timescale 1ns/100ps

module x_scoreboard
  import x_core_pkg::*, x_if_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // accepted writeback offload
  input  logic                  set_i,
  input  logic [REG_ADDR_W-1:0] set_addr_i,

  // coprocessor result
  input  logic                  result_valid_i,
  input  x_result_t             result_i,

  output logic [NR_REGS-1:0]    sb_o
);

  logic [NR_REGS-1:0] sb_d;
  logic [NR_REGS-1:0] sb_q;
  logic               result_hits_set;
  logic               result_clears;

  // result for the same nonzero register lands in the issue cycle
  assign result_hits_set = result_valid_i
                         & (result_i.rd == set_addr_i)
                         & (result_i.rd != '0);

  assign result_clears = result_valid_i & result_i.we;

  always_comb begin
    sb_d = sb_q;
    if (set_i && !result_hits_set) begin
      sb_d[set_addr_i] = 1'b1;
    end
    // clear wins over a set of the same register
    if (result_clears) begin
      sb_d[result_i.rd] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sb_q <= '0;
    end else begin
      sb_q <= sb_d;
    end
  end

  assign sb_o = sb_q;

endmodule

/* design/x_operand_check.sv */
`timescale 1ns/100ps

module x_operand_check
  import x_core_pkg::*, x_if_pkg::*;
(
  input  logic [REG_ADDR_W-1:0] rs_addr_i,
  input  logic                  used_i,
  input  logic [NR_REGS-1:0]    sb_i,

  // pipeline destinations
  input  pipe_wport_t           ex_wport_i,
  input  pipe_wport_t           wb_wport_i,
  input  pipe_wport_t           mem_wport_ex_i,
  input  logic                  ex_valid_i,

  // coprocessor result of this cycle
  input  logic                  result_valid_i,
  input  x_result_t             result_i,

  output operand_status_t       status_o
);

  logic pending;
  logic ex_hit;
  logic wb_hit;
  logic ex_load_hit;
  logic result_writes;

  assign pending = sb_i[rs_addr_i];

  // forwarding from a writing stage
  assign ex_hit = (rs_addr_i == ex_wport_i.addr) & ex_wport_i.we & ex_valid_i;
  assign wb_hit = (rs_addr_i == wb_wport_i.addr) & wb_wport_i.we & ex_valid_i;

  // load data in EX is not forwardable yet
  assign ex_load_hit = (rs_addr_i == mem_wport_ex_i.addr) & mem_wport_ex_i.we;

  assign result_writes = result_valid_i & result_i.we & (result_i.rd == rs_addr_i);

  always_comb begin
    status_o.ex_fwd = ex_hit;
    status_o.wb_fwd = wb_hit;
    status_o.ready  = (~pending | ex_hit | wb_hit)
                    & ~ex_load_hit
                    & ~((rs_addr_i == wb_wport_i.addr) & ~ex_valid_i);
    // pending writeback that this cycle does not resolve
    status_o.dep    = used_i & pending & ~result_writes;
  end

endmodule

/* design/x_dispatcher.sv */
`timescale 1ns/100ps

module x_dispatcher
  import x_core_pkg::*, x_if_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 rst_ni,

  // decode view
  input  logic                                 instr_valid_i,
  input  logic                                 unknown_insn_i,
  input  logic                                 branch_or_jump_i,
  input  priv_lvl_e                            priv_lvl_i,
  input  logic                                 id_ready_i,
  input  logic                                 ex_ready_i,
  input  logic                                 wb_ready_i,
  input  logic                                 data_req_dec_i,
  input  logic                                 mem_instr_wb_i,
  input  logic                                 illegal_clear_i,

  // from the operand checkers
  input  operand_status_t [RF_READ_PORTS-1:0]  status_i,

  // coprocessor side
  input  logic                                 issue_ready_i,
  input  x_issue_resp_t                        issue_resp_i,
  input  logic                                 mem_valid_i,
  input  logic                                 result_valid_i,

  output logic                                 issue_valid_o,
  output x_issue_req_t                         issue_req_o,
  output logic                                 commit_valid_o,
  output x_commit_t                            commit_o,
  output logic                                 mem_ready_o,
  output logic                                 mem_data_req_o,
  output logic                                 mem_result_valid_o,

  // to the scoreboard
  output logic                                 sb_set_o,

  output logic                                 stall_o,
  output logic                                 illegal_insn_o
);

  logic [X_ID_W-1:0]        id_q;
  logic                     offloaded_q;
  logic [3:0]               mem_cnt_q;
  logic                     illegal_q;
  logic                     fire;
  logic                     ls_fire;
  logic [RF_READ_PORTS-1:0] rs_valid;
  logic                     any_dep;
  logic                     any_ex_fwd;
  logic                     fwd_guard;
  logic                     outstanding_mem;
  logic                     not_ready;
  logic                     mem_no_fire;
  logic [X_MODE_W-1:0]      mode;

  ////////////////////////////////////////////////////////////
  // operand summary
  ////////////////////////////////////////////////////////////

  always_comb begin
    any_dep    = 1'b0;
    any_ex_fwd = 1'b0;
    for (int i = 0; i < RF_READ_PORTS; i++) begin
      rs_valid[i] = status_i[i].ready;
      any_dep     = any_dep | status_i[i].dep;
      any_ex_fwd  = any_ex_fwd | status_i[i].ex_fwd;
    end
  end

  // EX forward would race the result write
  assign fwd_guard = result_valid_i & any_ex_fwd;

  ////////////////////////////////////////////////////////////
  // issue and commit
  ////////////////////////////////////////////////////////////

  assign issue_valid_o = unknown_insn_i & instr_valid_i & ~branch_or_jump_i
                       & ~offloaded_q & ~fwd_guard;
  assign fire          = issue_valid_o & issue_ready_i;
  assign ls_fire       = fire & issue_resp_i.loadstore;

  always_comb begin
    case (priv_lvl_i)
      PRIV_LVL_M: mode = 2'b11;
      PRIV_LVL_H: mode = 2'b10;
      PRIV_LVL_S: mode = 2'b01;
      PRIV_LVL_U: mode = 2'b00;
      default:    mode = 2'b11;
    endcase
  end

  always_comb begin
    issue_req_o.rs_valid = rs_valid;
    issue_req_o.id       = id_q;
    issue_req_o.mode     = mode;
  end

  // commit mirrors the issue, never killed
  assign commit_valid_o = issue_valid_o;
  always_comb begin
    commit_o.id   = id_q;
    commit_o.kill = 1'b0;
  end

  assign sb_set_o = fire & issue_resp_i.writeback;

  ////////////////////////////////////////////////////////////
  // memory channel
  ////////////////////////////////////////////////////////////

  assign mem_ready_o        = ex_ready_i;
  assign mem_data_req_o     = mem_valid_i & ex_ready_i;
  assign mem_result_valid_o = mem_instr_wb_i & wb_ready_i;

  ////////////////////////////////////////////////////////////
  // stall
  ////////////////////////////////////////////////////////////

  assign outstanding_mem = data_req_dec_i & (mem_cnt_q != '0);
  assign not_ready       = issue_valid_o & ~issue_ready_i;
  assign mem_no_fire     = mem_data_req_o & ~fire;

  assign stall_o = any_dep | outstanding_mem | not_ready | mem_no_fire | fwd_guard;

  assign illegal_insn_o = illegal_q;

  ////////////////////////////////////////////////////////////
  // state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_q        <= '0;
      offloaded_q <= 1'b0;
      mem_cnt_q   <= '0;
      illegal_q   <= 1'b0;
    end else begin
      if (fire) begin
        id_q <= id_q + 1'b1;
      end
      // decode stage moving on frees the flag
      if (id_ready_i) begin
        offloaded_q <= 1'b0;
      end else if (fire) begin
        offloaded_q <= 1'b1;
      end
      // simultaneous offload and request cancel out
      if (ls_fire && !mem_data_req_o) begin
        mem_cnt_q <= mem_cnt_q + 1'b1;
      end else if (!ls_fire && mem_data_req_o) begin
        mem_cnt_q <= mem_cnt_q - 1'b1;
      end
      // rejected offer held until the core clears it
      if (illegal_clear_i) begin
        illegal_q <= 1'b0;
      end else if (fire && !issue_resp_i.accept) begin
        illegal_q <= 1'b1;
      end
    end
  end

endmodule

/* design/x_offload_unit.sv */
`timescale 1ns/100ps

module x_offload_unit
  import x_core_pkg::*, x_if_pkg::*;
(
  input  logic                                    clk_i,
  input  logic                                    rst_ni,

  // decode view from the core
  input  logic                                    instr_valid_i,
  input  logic                                    unknown_insn_i,
  input  logic                                    branch_or_jump_i,
  input  logic [RF_READ_PORTS-1:0][REG_ADDR_W-1:0] rs_addr_i,
  input  logic [RF_READ_PORTS-1:0]                regs_used_i,
  input  logic [REG_ADDR_W-1:0]                   rd_addr_i,
  input  priv_lvl_e                               priv_lvl_i,
  input  logic                                    id_ready_i,
  input  logic                                    ex_valid_i,
  input  logic                                    ex_ready_i,
  input  logic                                    wb_ready_i,
  input  pipe_wport_t                             ex_wport_i,
  input  pipe_wport_t                             wb_wport_i,
  input  pipe_wport_t                             mem_wport_ex_i,
  input  logic                                    data_req_dec_i,
  input  logic                                    mem_instr_wb_i,
  input  logic                                    illegal_clear_i,

  // coprocessor
  input  logic                                    issue_ready_i,
  input  x_issue_resp_t                           issue_resp_i,
  input  logic                                    mem_valid_i,
  input  logic                                    result_valid_i,
  input  x_result_t                               result_i,

  output logic                                    issue_valid_o,
  output x_issue_req_t                            issue_req_o,
  output logic                                    commit_valid_o,
  output x_commit_t                               commit_o,
  output logic                                    mem_ready_o,
  output logic                                    mem_data_req_o,
  output logic                                    mem_result_valid_o,
  output logic [RF_READ_PORTS-1:0]                ex_fwd_o,
  output logic [RF_READ_PORTS-1:0]                wb_fwd_o,
  output logic                                    stall_o,
  output logic                                    illegal_insn_o
);

  logic [NR_REGS-1:0]                   sb_q;
  logic                                 sb_set;
  operand_status_t [RF_READ_PORTS-1:0]  status;

  x_scoreboard u_scoreboard (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .set_i          (sb_set),
    .set_addr_i     (rd_addr_i),
    .result_valid_i (result_valid_i),
    .result_i       (result_i),
    .sb_o           (sb_q)
  );

  // one checker per source operand
  for (genvar i = 0; i < RF_READ_PORTS; i++) begin : gen_opchk
    x_operand_check u_opchk (
      .rs_addr_i      (rs_addr_i[i]),
      .used_i         (regs_used_i[i]),
      .sb_i           (sb_q),
      .ex_wport_i     (ex_wport_i),
      .wb_wport_i     (wb_wport_i),
      .mem_wport_ex_i (mem_wport_ex_i),
      .ex_valid_i     (ex_valid_i),
      .result_valid_i (result_valid_i),
      .result_i       (result_i),
      .status_o       (status[i])
    );

    assign ex_fwd_o[i] = status[i].ex_fwd;
    assign wb_fwd_o[i] = status[i].wb_fwd;
  end

  x_dispatcher u_dispatcher (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .instr_valid_i      (instr_valid_i),
    .unknown_insn_i     (unknown_insn_i),
    .branch_or_jump_i   (branch_or_jump_i),
    .priv_lvl_i         (priv_lvl_i),
    .id_ready_i         (id_ready_i),
    .ex_ready_i         (ex_ready_i),
    .wb_ready_i         (wb_ready_i),
    .data_req_dec_i     (data_req_dec_i),
    .mem_instr_wb_i     (mem_instr_wb_i),
    .illegal_clear_i    (illegal_clear_i),
    .status_i           (status),
    .issue_ready_i      (issue_ready_i),
    .issue_resp_i       (issue_resp_i),
    .mem_valid_i        (mem_valid_i),
    .result_valid_i     (result_valid_i),
    .issue_valid_o      (issue_valid_o),
    .issue_req_o        (issue_req_o),
    .commit_valid_o     (commit_valid_o),
    .commit_o           (commit_o),
    .mem_ready_o        (mem_ready_o),
    .mem_data_req_o     (mem_data_req_o),
    .mem_result_valid_o (mem_result_valid_o),
    .sb_set_o           (sb_set),
    .stall_o            (stall_o),
    .illegal_insn_o     (illegal_insn_o)
  );

endmodule

/* verif/tb_x_model.svh */
`ifndef TB_X_MODEL_SVH
`define TB_X_MODEL_SVH

////////////////////////////////////////////////////////////
// random source
////////////////////////////////////////////////////////////

logic [31:0] lfsr_q = 32'h7319_eaf7;

// taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  logic fb;
  fb = s[31] ^ s[21] ^ s[1] ^ s[0];
  return {s[30:0], fb};
endfunction

// one lfsr step per returned bit
function automatic logic [31:0] draw_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int k = 0; k < n; k++) begin
    lfsr_q = lfsr_next(lfsr_q);
    v = {v[30:0], lfsr_q[0]};
  end
  return v;
endfunction

////////////////////////////////////////////////////////////
// reference model
////////////////////////////////////////////////////////////

logic [NR_REGS-1:0]       m_sb;
logic [X_ID_W-1:0]        m_id;
logic                     m_offloaded;
logic [3:0]               m_mem_cnt;
logic                     m_illegal;
logic                     exp_issue_valid;
logic                     exp_fire;
logic                     exp_stall;
logic [1:0]               exp_mode;
logic [RF_READ_PORTS-1:0] exp_rs_valid;
logic [RF_READ_PORTS-1:0] exp_ex_fwd;
logic [RF_READ_PORTS-1:0] exp_wb_fwd;
logic [RF_READ_PORTS-1:0] exp_dep;
int unsigned              n_checks;
int unsigned              n_errors;
int unsigned              n_fires;
int unsigned              n_dep_stalls;

task automatic model_reset();
  m_sb        = '0;
  m_id        = '0;
  m_offloaded = 1'b0;
  m_mem_cnt   = '0;
  m_illegal   = 1'b0;
endtask

// expected outputs of this cycle from the current inputs and model state
task automatic predict();
  logic guard;
  logic same_wb;
  guard = 1'b0;
  for (int i = 0; i < RF_READ_PORTS; i++) begin
    exp_ex_fwd[i] = ex_valid_i && ex_wport_i.we && rs_addr_i[i] == ex_wport_i.addr;
    exp_wb_fwd[i] = ex_valid_i && wb_wport_i.we && rs_addr_i[i] == wb_wport_i.addr;
    same_wb = rs_addr_i[i] == wb_wport_i.addr;
    exp_rs_valid[i] = (!m_sb[rs_addr_i[i]] || exp_ex_fwd[i] || exp_wb_fwd[i])
                    && !(mem_wport_ex_i.we && rs_addr_i[i] == mem_wport_ex_i.addr)
                    && !(same_wb && !ex_valid_i);
    exp_dep[i] = regs_used_i[i] && m_sb[rs_addr_i[i]]
               && !(result_valid_i && result_i.we && result_i.rd == rs_addr_i[i]);
    guard = guard || (result_valid_i && exp_ex_fwd[i]);
  end
  exp_issue_valid = instr_valid_i && unknown_insn_i && !branch_or_jump_i
                  && !m_offloaded && !guard;
  exp_fire = exp_issue_valid && issue_ready_i;
  case (priv_lvl_i)
    PRIV_LVL_M: exp_mode = 2'd3;
    PRIV_LVL_H: exp_mode = 2'd2;
    PRIV_LVL_S: exp_mode = 2'd1;
    PRIV_LVL_U: exp_mode = 2'd0;
  endcase
  exp_stall = (|exp_dep) || (data_req_dec_i && m_mem_cnt != 0)
            || (exp_issue_valid && !issue_ready_i)
            || (mem_valid_i && ex_ready_i && !exp_fire) || guard;
endtask

// state after the coming rising edge
task automatic advance_model();
  logic mem_req;
  logic ls_fire;
  logic same_rd;
  mem_req = mem_valid_i && ex_ready_i;
  ls_fire = exp_fire && issue_resp_i.loadstore;
  same_rd = result_valid_i && result_i.rd == rd_addr_i && result_i.rd != 0;
  if (exp_fire && issue_resp_i.writeback && !same_rd) begin
    m_sb[rd_addr_i] = 1'b1;
  end
  if (result_valid_i && result_i.we) begin
    m_sb[result_i.rd] = 1'b0;
  end
  if (exp_fire) begin
    m_id = m_id + 1'b1;
    n_fires++;
  end
  if (id_ready_i) begin
    m_offloaded = 1'b0;
  end else if (exp_fire) begin
    m_offloaded = 1'b1;
  end
  if (ls_fire && !mem_req) begin
    m_mem_cnt = m_mem_cnt + 1'b1;
  end else if (!ls_fire && mem_req) begin
    m_mem_cnt = m_mem_cnt - 1'b1;
  end
  // flag stays up until the core clears it
  if (illegal_clear_i) begin
    m_illegal = 1'b0;
  end else if (exp_fire && !issue_resp_i.accept) begin
    m_illegal = 1'b1;
  end
  if (|exp_dep) begin
    n_dep_stalls++;
  end
endtask

////////////////////////////////////////////////////////////
// checking
////////////////////////////////////////////////////////////

task automatic check_val(input string what, input logic [31:0] got,
                         input logic [31:0] exp);
  n_checks++;
  assert (got === exp) else begin
    $display("ERROR @ %0t: %s is %0h, expected %0h", $time, what, got, exp);
    n_errors++;
  end
endtask

task automatic compare_outputs();
  check_val("issue_valid_o", issue_valid_o, exp_issue_valid);
  check_val("issue_req_o.rs_valid", issue_req_o.rs_valid, exp_rs_valid);
  check_val("issue_req_o.id", issue_req_o.id, m_id);
  check_val("issue_req_o.mode", issue_req_o.mode, exp_mode);
  check_val("commit_valid_o", commit_valid_o, exp_issue_valid);
  check_val("commit_o.id", commit_o.id, m_id);
  check_val("commit_o.kill", commit_o.kill, 1'b0);
  check_val("ex_fwd_o", ex_fwd_o, exp_ex_fwd);
  check_val("wb_fwd_o", wb_fwd_o, exp_wb_fwd);
  check_val("stall_o", stall_o, exp_stall);
  check_val("illegal_insn_o", illegal_insn_o, m_illegal);
  check_val("mem_ready_o", mem_ready_o, ex_ready_i);
  check_val("mem_data_req_o", mem_data_req_o, mem_valid_i && ex_ready_i);
  check_val("mem_result_valid_o", mem_result_valid_o, mem_instr_wb_i && wb_ready_i);
endtask

`endif

/* verif/tb_x_offload_unit.sv */
`timescale 1ns/100ps

module tb_x_offload_unit
  import x_core_pkg::*, x_if_pkg::*;
();

  localparam int unsigned CLK_PERIOD = 4;
  localparam int unsigned RST_CYCLES = 4;
  localparam int unsigned NUM_CYCLES = 2000;
  localparam int unsigned MARGIN     = 200;

  logic                                    clk_i;
  logic                                    rst_ni;
  logic                                    instr_valid_i;
  logic                                    unknown_insn_i;
  logic                                    branch_or_jump_i;
  logic [RF_READ_PORTS-1:0][REG_ADDR_W-1:0] rs_addr_i;
  logic [RF_READ_PORTS-1:0]                regs_used_i;
  logic [REG_ADDR_W-1:0]                   rd_addr_i;
  priv_lvl_e                               priv_lvl_i;
  logic                                    id_ready_i;
  logic                                    ex_valid_i;
  logic                                    ex_ready_i;
  logic                                    wb_ready_i;
  pipe_wport_t                             ex_wport_i;
  pipe_wport_t                             wb_wport_i;
  pipe_wport_t                             mem_wport_ex_i;
  logic                                    data_req_dec_i;
  logic                                    mem_instr_wb_i;
  logic                                    illegal_clear_i;
  logic                                    issue_ready_i;
  x_issue_resp_t                           issue_resp_i;
  logic                                    mem_valid_i;
  logic                                    result_valid_i;
  x_result_t                               result_i;
  logic                                    issue_valid_o;
  x_issue_req_t                            issue_req_o;
  logic                                    commit_valid_o;
  x_commit_t                               commit_o;
  logic                                    mem_ready_o;
  logic                                    mem_data_req_o;
  logic                                    mem_result_valid_o;
  logic [RF_READ_PORTS-1:0]                ex_fwd_o;
  logic [RF_READ_PORTS-1:0]                wb_fwd_o;
  logic                                    stall_o;
  logic                                    illegal_insn_o;

  `include "tb_x_model.svh"

  x_offload_unit x_offload_unit_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic set_idle_inputs();
    {instr_valid_i, unknown_insn_i, branch_or_jump_i} = '0;
    rs_addr_i   = '0;
    regs_used_i = '0;
    rd_addr_i   = '0;
    priv_lvl_i  = PRIV_LVL_M;
    {id_ready_i, ex_valid_i, ex_ready_i, wb_ready_i} = '0;
    ex_wport_i     = '0;
    wb_wport_i     = '0;
    mem_wport_ex_i = '0;
    {data_req_dec_i, mem_instr_wb_i, illegal_clear_i} = '0;
    {issue_ready_i, mem_valid_i, result_valid_i} = '0;
    issue_resp_i = '0;
    result_i     = '0;
  endtask

  // addresses kept to x0..x7 so hazards show up often
  task automatic drive_inputs();
    instr_valid_i    = draw_bits(1) == 1;
    unknown_insn_i   = draw_bits(2) != 0;
    branch_or_jump_i = draw_bits(3) == 0;
    for (int i = 0; i < RF_READ_PORTS; i++) begin
      rs_addr_i[i] = REG_ADDR_W'(draw_bits(3));
    end
    regs_used_i         = RF_READ_PORTS'(draw_bits(RF_READ_PORTS));
    rd_addr_i           = REG_ADDR_W'(draw_bits(3));
    priv_lvl_i          = priv_lvl_e'(draw_bits(2));
    id_ready_i          = draw_bits(1) == 1;
    ex_valid_i          = draw_bits(1) == 1;
    ex_ready_i          = draw_bits(2) != 0;
    wb_ready_i          = draw_bits(1) == 1;
    ex_wport_i.addr     = REG_ADDR_W'(draw_bits(3));
    ex_wport_i.we       = draw_bits(1) == 1;
    wb_wport_i.addr     = REG_ADDR_W'(draw_bits(3));
    wb_wport_i.we       = draw_bits(1) == 1;
    mem_wport_ex_i.addr = REG_ADDR_W'(draw_bits(3));
    mem_wport_ex_i.we   = draw_bits(2) == 0;
    data_req_dec_i      = draw_bits(1) == 1;
    mem_instr_wb_i      = draw_bits(1) == 1;
    illegal_clear_i     = draw_bits(3) == 0;
    // coprocessor side, back-pressure about a quarter of the time
    issue_ready_i          = draw_bits(2) != 0;
    issue_resp_i.accept    = draw_bits(3) != 0;
    issue_resp_i.writeback = draw_bits(1) == 1;
    issue_resp_i.loadstore = draw_bits(2) == 0;
    mem_valid_i            = draw_bits(2) == 0;
    result_valid_i         = draw_bits(2) == 0;
    result_i.rd            = REG_ADDR_W'(draw_bits(3));
    result_i.we            = draw_bits(2) != 0;
  endtask

  initial begin
    set_idle_inputs();
    model_reset();
    rst_ni = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    // idle cycle right after reset
    #1;
    predict();
    compare_outputs();
    advance_model();
    for (int c = 0; c < NUM_CYCLES; c++) begin
      @(negedge clk_i);
      drive_inputs();
      #1;
      predict();
      compare_outputs();
      advance_model();
    end
    $display("checks %0d, errors %0d, fires %0d, dependency cycles %0d",
             n_checks, n_errors, n_fires, n_dep_stalls);
    if (n_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((NUM_CYCLES + RST_CYCLES + MARGIN) * CLK_PERIOD);
    $display("watchdog expired before the random test loop finished");
    $display("Test failed");
    $finish;
  end

endmodule

/* compile.f */
+incdir+verif
design/x_core_pkg.sv
design/x_if_pkg.sv
design/x_scoreboard.sv
design/x_operand_check.sv
design/x_dispatcher.sv
design/x_offload_unit.sv
verif/tb_x_offload_unit.sv

/* Bender.yml */
package:
  name: x_offload_unit

sources:
  # packages first, then the design bottom up
  - files:
      - design/x_core_pkg.sv
      - design/x_if_pkg.sv
      - design/x_scoreboard.sv
      - design/x_operand_check.sv
      - design/x_dispatcher.sv
      - design/x_offload_unit.sv

  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_x_offload_unit.sv
